/* design/int_pkg.sv */
// Interrupt unit definitions
// Microcode ACTION field, the STI and CLI action codes, the state
// encoding of the request FSM and the width of the taken counter

package int_pkg;

   ////////////////////////////////////////////////////////////////////
   // Microcode fields
   ////////////////////////////////////////////////////////////////////

   // ACTION field of the microinstruction
   typedef logic [3:0] action_t;

   // High bit selects the upper bank of actions
   // Low three bits pick the strobe within the bank
   localparam action_t ACT_STI = 4'b0_011;
   localparam action_t ACT_CLI = 4'b0_100;

   ////////////////////////////////////////////////////////////////////
   // Request FSM
   ////////////////////////////////////////////////////////////////////

   // IDLE     no request seen
   // PENDING  request held until the instruction ends
   // SIGNALLED  request presented to the control unit
   typedef enum logic [1:0] {
      INT_IDLE      = 2'd0,
      INT_PENDING   = 2'd1,
      INT_SIGNALLED = 2'd2
   } int_state_t;

   ////////////////////////////////////////////////////////////////////
   // Statistics
   ////////////////////////////////////////////////////////////////////

   // Count of interrupts taken, wraps at full scale
   typedef logic [15:0] count_t;

endpackage

/* design/int_wb_pkg.sv */
// Register port definitions for the interrupt unit
// Wishbone classic address and data types and the register map
// seen by the host or front panel

package int_wb_pkg;

   ////////////////////////////////////////////////////////////////////
   // Bus types
   ////////////////////////////////////////////////////////////////////

   // Word address, four slots
   typedef logic [1:0]  wb_addr_t;

   // Data word, same width as the CPU bus
   typedef logic [15:0] wb_data_t;

   ////////////////////////////////////////////////////////////////////
   // Register map
   ////////////////////////////////////////////////////////////////////

   // Read only view of fi, irq_req and irqs
   localparam wb_addr_t REG_STATUS  = 2'd0;
   // Write only strobes for the interrupt flag
   localparam wb_addr_t REG_CONTROL = 2'd1;
   // Interrupts taken, write clears
   localparam wb_addr_t REG_COUNT   = 2'd2;

   // Control register bits
   localparam int CTL_SET_FI = 0;
   localparam int CTL_CLR_FI = 1;

endpackage

/* design/irq_sync.sv */
// External interrupt synchronizer
// Brings the active-low interrupt line into the clk4 domain, requires
// FILTER_LEN consecutive low samples and masks the request with FI

module irq_sync #(
   parameter int unsigned FILTER_LEN = 3
) (
   input  logic clk4,
   input  logic reset,
   input  logic irq_n,
   input  logic fi,
   output logic irq_req
);

   // Counter must hold the value FILTER_LEN itself
   localparam int unsigned CNT_W = $clog2(FILTER_LEN + 1);

   logic             irq_n_s1;
   logic             irq_n_s2;
   logic [CNT_W-1:0] low_cnt;

   ////////////////////////////////////////////////////////////////////
   // Two flop synchronizer
   ////////////////////////////////////////////////////////////////////

   // Resets to the idle (high) level of the line
   always_ff @(posedge clk4) begin
      if (reset) begin
         irq_n_s1 <= 1'b1;
         irq_n_s2 <= 1'b1;
      end else begin
         irq_n_s1 <= irq_n;
         irq_n_s2 <= irq_n_s1;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Glitch filter
   ////////////////////////////////////////////////////////////////////

   // Saturating run length of low samples
   // Held at zero while FI is clear, like the forced-off input flop
   always_ff @(posedge clk4) begin
      if (reset || !fi || irq_n_s2) begin
         low_cnt <= '0;
      end else if (low_cnt != CNT_W'(FILTER_LEN)) begin
         low_cnt <= low_cnt + CNT_W'(1);
      end
   end

   // Drops as soon as the synchronized line goes high again
   assign irq_req = (low_cnt == CNT_W'(FILTER_LEN)) && !irq_n_s2;

   // Masking by FI takes one edge
   a_mask_by_fi : assert property (@(posedge clk4) disable iff (reset)
      !$past(fi) |-> !irq_req);

endmodule

/* design/int_fsm.sv */
// Interrupt control block
// Decodes STI and CLI from the microcode ACTION field, holds the
// interrupt flag FI and presents a filtered request to the control
// unit only at the end of the current instruction

module int_fsm (
   input  logic             clk4,
   input  logic             reset,
   input  int_pkg::action_t action,
   input  logic             ibus15,
   input  logic             flagwe,
   input  logic             instr_end,
   input  logic             irq_req,
   input  logic             host_set_fi,
   input  logic             host_clr_fi,
   output logic             fi,
   output logic             irqs,
   output logic             irq_taken
);

   import int_pkg::*;

   logic       sti;
   logic       cli;
   int_state_t state;
   int_state_t state_next;
   logic       irqs_d;

   ////////////////////////////////////////////////////////////////////
   // Action decode
   ////////////////////////////////////////////////////////////////////

   // Only one code is live per microinstruction
   assign sti = (action == ACT_STI);
   assign cli = (action == ACT_CLI);

   ////////////////////////////////////////////////////////////////////
   // Interrupt flag
   ////////////////////////////////////////////////////////////////////

   // Microcode wins over the host port
   // CLI before STI, then a flag load from bit 15 of the bus
   always_ff @(posedge clk4) begin
      if (reset) begin
         fi <= 1'b0;
      end else if (cli) begin
         fi <= 1'b0;
      end else if (sti) begin
         fi <= 1'b1;
      end else if (flagwe) begin
         fi <= ibus15;
      end else if (host_clr_fi) begin
         fi <= 1'b0;
      end else if (host_set_fi) begin
         fi <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Request FSM
   ////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk4) begin
      if (reset) begin
         state <= INT_IDLE;
      end else begin
         state <= state_next;
      end
   end

   // Instruction end samples the request in every state
   always_comb begin
      state_next = state;
      case (state)
         INT_IDLE: begin
            if (instr_end) begin
               state_next = irq_req ? INT_SIGNALLED : INT_IDLE;
            end else if (irq_req) begin
               state_next = INT_PENDING;
            end
         end
         INT_PENDING: begin
            // Wait here for the current instruction to finish
            if (instr_end) begin
               state_next = irq_req ? INT_SIGNALLED : INT_IDLE;
            end
         end
         INT_SIGNALLED: begin
            // Request withdrawn by the time the instruction ends
            if (instr_end && !irq_req) begin
               state_next = INT_IDLE;
            end
         end
         default: begin
            state_next = INT_IDLE;
         end
      endcase

      // CLI overrides any instruction end in the same cycle
      if (cli) begin
         state_next = INT_IDLE;
      end
   end

   // Line to the control unit
   assign irqs = (state == INT_SIGNALLED);

   ////////////////////////////////////////////////////////////////////
   // Taken pulse
   ////////////////////////////////////////////////////////////////////

   // One cycle pulse in the cycle after irqs rises
   always_ff @(posedge clk4) begin
      if (reset) begin
         irqs_d    <= 1'b0;
         irq_taken <= 1'b0;
      end else begin
         irqs_d    <= irqs;
         irq_taken <= irqs && !irqs_d;
      end
   end

   // Request reaches the control unit only at an instruction end
   a_irqs_at_end : assert property (@(posedge clk4) disable iff (reset)
      $rose(irqs) |-> $past(instr_end));

   // CLI withdraws the request at the next edge
   a_cli_clears : assert property (@(posedge clk4) disable iff (reset)
      $past(cli) |-> !irqs);

endmodule

/* design/int_regs.sv */
// Interrupt unit register port
// Wishbone classic slave giving the host a status view, set and clear
// strobes for FI and a wrapping count of interrupts taken

module int_regs (
   input  logic                  clk4,
   input  logic                  reset,
   input  logic                  cyc,
   input  logic                  stb,
   input  logic                  we,
   input  int_wb_pkg::wb_addr_t  adr,
   input  int_wb_pkg::wb_data_t  dat_w,
   output int_wb_pkg::wb_data_t  dat_r,
   output logic                  ack,
   input  logic                  fi,
   input  logic                  irq_req,
   input  logic                  irqs,
   input  logic                  irq_taken,
   output logic                  host_set_fi,
   output logic                  host_clr_fi
);

   import int_pkg::*;
   import int_wb_pkg::*;

   logic   bus_req;
   logic   bus_wr;
   logic   ctl_wr;
   logic   cnt_wr;
   count_t irq_count;

   ////////////////////////////////////////////////////////////////////
   // Bus handshake
   ////////////////////////////////////////////////////////////////////

   // New access, not yet acknowledged
   assign bus_req = cyc && stb && !ack;
   assign bus_wr  = bus_req && we;

   // Single cycle ack, master drops stb after it
   always_ff @(posedge clk4) begin
      if (reset) begin
         ack <= 1'b0;
      end else begin
         ack <= bus_req;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Write side
   ////////////////////////////////////////////////////////////////////

   assign ctl_wr = bus_wr && (adr == REG_CONTROL);
   assign cnt_wr = bus_wr && (adr == REG_COUNT);

   // Strobes act on FI at the same edge that raises ack
   assign host_set_fi = ctl_wr && dat_w[CTL_SET_FI];
   assign host_clr_fi = ctl_wr && dat_w[CTL_CLR_FI];

   // Interrupts taken
   // A pulse coinciding with the clear is still counted
   always_ff @(posedge clk4) begin
      if (reset) begin
         irq_count <= '0;
      end else if (cnt_wr) begin
         irq_count <= irq_taken ? count_t'(1) : count_t'(0);
      end else if (irq_taken) begin
         irq_count <= irq_count + count_t'(1);
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Read side
   ////////////////////////////////////////////////////////////////////

   // Captured with the ack edge, valid while ack is high
   always_ff @(posedge clk4) begin
      if (bus_req) begin
         case (adr)
            REG_STATUS: begin
               dat_r <= {13'd0, irqs, irq_req, fi};
            end
            REG_COUNT: begin
               dat_r <= irq_count;
            end
            // Control reads back zero, unmapped slot too
            default: begin
               dat_r <= '0;
            end
         endcase
      end
   end

   // Ack lasts one cycle and never outside an active cycle
   a_ack_pulse : assert property (@(posedge clk4) disable iff (reset)
      ack |-> (cyc && stb) ##1 !ack);

endmodule

/* design/int_unit.sv */
// Interrupt unit top level
// Synchronizer and glitch filter, the interrupt control block and the
// Wishbone register port, wired together

module int_unit #(
   parameter int unsigned FILTER_LEN = 3
) (
   input  logic                  clk4,
   input  logic                  reset,
   // Microcode side
   input  int_pkg::action_t      action,
   input  logic                  ibus15,
   input  logic                  flagwe,
   input  logic                  instr_end,
   // External request, active low
   input  logic                  irq_n,
   output logic                  fi,
   output logic                  irqs,
   // Register port
   input  logic                  cyc,
   input  logic                  stb,
   input  logic                  we,
   input  int_wb_pkg::wb_addr_t  adr,
   input  int_wb_pkg::wb_data_t  dat_w,
   output int_wb_pkg::wb_data_t  dat_r,
   output logic                  ack
);

   logic irq_req;
   logic host_set_fi;
   logic host_clr_fi;
   logic irq_taken;

   // Filtered and masked request
   irq_sync #(
      .FILTER_LEN (FILTER_LEN)
   ) i_irq_sync (
      .clk4    (clk4),
      .reset   (reset),
      .irq_n   (irq_n),
      .fi      (fi),
      .irq_req (irq_req)
   );

   // Flag and request to the control unit
   int_fsm i_int_fsm (
      .clk4        (clk4),
      .reset       (reset),
      .action      (action),
      .ibus15      (ibus15),
      .flagwe      (flagwe),
      .instr_end   (instr_end),
      .irq_req     (irq_req),
      .host_set_fi (host_set_fi),
      .host_clr_fi (host_clr_fi),
      .fi          (fi),
      .irqs        (irqs),
      .irq_taken   (irq_taken)
   );

   // Host view
   int_regs i_int_regs (
      .clk4        (clk4),
      .reset       (reset),
      .cyc         (cyc),
      .stb         (stb),
      .we          (we),
      .adr         (adr),
      .dat_w       (dat_w),
      .dat_r       (dat_r),
      .ack         (ack),
      .fi          (fi),
      .irq_req     (irq_req),
      .irqs        (irqs),
      .irq_taken   (irq_taken),
      .host_set_fi (host_set_fi),
      .host_clr_fi (host_clr_fi)
   );

endmodule

/* verification/tb_int_unit.sv */
// Testbench for the interrupt unit
// Drives microcode strobes, the external line and the Wishbone port,
// runs a cycle model beside the DUT and compares them with assertions

module tb_int_unit;

   timeunit 1ns;
   timeprecision 100ps;

   import int_pkg::*;
   import int_wb_pkg::*;

   localparam int unsigned FILTER_LEN = 3;
   localparam int BUS_TIMEOUT = 20;
   localparam int IRQ_TIMEOUT = 80;
   localparam action_t ACT_NOP = 4'h0;

   logic clk4;
   logic reset;
   action_t action;
   logic ibus15;
   logic flagwe;
   logic instr_end;
   logic irq_n;
   logic fi;
   logic irqs;
   logic cyc;
   logic stb;
   logic we;
   wb_addr_t adr;
   wb_data_t dat_w;
   wb_data_t dat_r;
   logic ack;

   int errors;
   int test_errors_start;
   int tests_run;
   int tests_bad;
   logic [31:0] rng;
   int end_gap;

   int_unit #(
      .FILTER_LEN (FILTER_LEN)
   ) i_dut (
      .clk4 (clk4), .reset (reset), .action (action), .ibus15 (ibus15),
      .flagwe (flagwe), .instr_end (instr_end), .irq_n (irq_n), .fi (fi),
      .irqs (irqs), .cyc (cyc), .stb (stb), .we (we), .adr (adr),
      .dat_w (dat_w), .dat_r (dat_r), .ack (ack)
   );

   initial begin
      clk4 = 1'b0;
      forever #50 clk4 = ~clk4;
   end

   //////////////////////////////////////////////////////////////////////
   // Cycle model
   //////////////////////////////////////////////////////////////////////

   logic line_d1;
   logic line_d2;
   int unsigned low_run;
   logic fi_m;
   logic irqs_m;
   logic irqs_prev_m;
   logic taken_m;
   count_t count_m;
   logic ack_m;
   logic rd_m;
   wb_data_t exp_rd_m;
   logic req_m;
   logic bus_req_m;
   logic host_set_m;
   logic host_clr_m;

   // Request needs FILTER_LEN low samples behind two sync stages
   assign req_m = (low_run == FILTER_LEN) && !line_d2;
   assign bus_req_m = cyc && stb && !ack_m;
   assign host_set_m = bus_req_m && we && (adr == REG_CONTROL) && dat_w[CTL_SET_FI];
   assign host_clr_m = bus_req_m && we && (adr == REG_CONTROL) && dat_w[CTL_CLR_FI];

   always @(posedge clk4) begin
      if (reset) begin
         line_d1 <= 1'b1;
         line_d2 <= 1'b1;
         low_run <= 0;
         fi_m <= 1'b0;
         irqs_m <= 1'b0;
         irqs_prev_m <= 1'b0;
         taken_m <= 1'b0;
         count_m <= '0;
         ack_m <= 1'b0;
         rd_m <= 1'b0;
      end else begin
         line_d1 <= irq_n;
         line_d2 <= line_d1;
         if (!fi_m || line_d2) begin
            low_run <= 0;
         end else if (low_run < FILTER_LEN) begin
            low_run <= low_run + 1;
         end
         // Flag priority puts microcode ahead of the host
         if (action == ACT_CLI) fi_m <= 1'b0;
         else if (action == ACT_STI) fi_m <= 1'b1;
         else if (flagwe) fi_m <= ibus15;
         else if (host_clr_m) fi_m <= 1'b0;
         else if (host_set_m) fi_m <= 1'b1;
         // Request only changes at an instruction end
         // CLI drops it whatever the instruction end does
         if (action == ACT_CLI) irqs_m <= 1'b0;
         else if (instr_end) irqs_m <= req_m;
         irqs_prev_m <= irqs_m;
         taken_m <= irqs_m && !irqs_prev_m;
         if (bus_req_m && we && (adr == REG_COUNT)) count_m <= taken_m ? 16'd1 : 16'd0;
         else if (taken_m) count_m <= count_m + 16'd1;
         ack_m <= bus_req_m;
         if (bus_req_m) begin
            rd_m <= !we;
            if (adr == REG_STATUS) exp_rd_m <= {13'd0, irqs_m, req_m, fi_m};
            else if (adr == REG_COUNT) exp_rd_m <= count_m;
            else exp_rd_m <= '0;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Checks
   //////////////////////////////////////////////////////////////////////

   function automatic void note_mismatch(string name, logic [15:0] exp, logic [15:0] act);
      errors++;
      $display("FAIL %0d ns %s expected %h actual %h", $time, name, exp, act);
   endfunction

   a_fi : assert property (@(posedge clk4) disable iff (reset) fi == fi_m)
      else note_mismatch("fi", 16'($sampled(fi_m)), 16'($sampled(fi)));
   a_irqs : assert property (@(posedge clk4) disable iff (reset) irqs == irqs_m)
      else note_mismatch("irqs", 16'($sampled(irqs_m)), 16'($sampled(irqs)));
   a_ack : assert property (@(posedge clk4) disable iff (reset) ack == ack_m)
      else note_mismatch("ack", 16'($sampled(ack_m)), 16'($sampled(ack)));
   // Read data valid while ack is high
   a_read : assert property (@(posedge clk4) disable iff (reset)
      (ack && rd_m) |-> dat_r == exp_rd_m)
      else note_mismatch("dat_r", $sampled(exp_rd_m), $sampled(dat_r));
   a_one_ack : assert property (@(posedge clk4) disable iff (reset) ack |=> !ack)
      else begin
         errors++;
         $display("ack stayed high for more than one cycle at %0d ns", $time);
      end

   //////////////////////////////////////////////////////////////////////
   // Stimulus helpers
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Steps one clock per cycle and lets each strobe last a single edge
   // Instruction ends come 3 to 10 cycles apart
   task automatic advance(input int cycles);
      int i;
      for (i = 0; i < cycles; i++) begin
         @(posedge clk4);
         #5;
         action = ACT_NOP;
         flagwe = 1'b0;
         ibus15 = 1'b0;
         if (end_gap == 0) begin
            instr_end = 1'b1;
            rng = next_random(rng);
            end_gap = 2 + int'(rng[2:0]);
         end else begin
            instr_end = 1'b0;
            end_gap = end_gap - 1;
         end
      end
   endtask

   task automatic issue(input action_t act, input logic load, input logic bit15);
      action = act;
      flagwe = load;
      ibus15 = bit15;
      advance(1);
   endtask

   // Holds the cycle over the edge that samples ack and drops it afterwards
   task automatic bus_access(input logic write, input wb_addr_t a, input wb_data_t d);
      int waited;
      waited = 0;
      cyc = 1'b1;
      stb = 1'b1;
      we = write;
      adr = a;
      dat_w = d;
      advance(1);
      while (!ack && waited < BUS_TIMEOUT) begin
         advance(1);
         waited++;
      end
      if (!ack) begin
         errors++;
         $display("Timeout: register %0d gave no ack within %0d cycles", a, BUS_TIMEOUT);
      end else begin
         advance(1);
      end
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
   endtask

   task automatic wait_for_irqs(input logic level);
      int waited;
      waited = 0;
      while (irqs !== level && waited < IRQ_TIMEOUT) begin
         advance(1);
         waited++;
      end
      if (irqs !== level) begin
         errors++;
         $display("Timeout: irqs did not go to %b within %0d cycles", level, IRQ_TIMEOUT);
      end
   endtask

   task automatic close_test(input string name);
      tests_run++;
      if (errors != test_errors_start) tests_bad++;
      $display("test %-22s %0d errors", name, errors - test_errors_start);
      test_errors_start = errors;
   endtask

   //////////////////////////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      reset = 1'b1;
      action = ACT_NOP;
      ibus15 = 1'b0;
      flagwe = 1'b0;
      instr_end = 1'b0;
      irq_n = 1'b1;
      cyc = 1'b0;
      stb = 1'b0;
      we = 1'b0;
      adr = '0;
      dat_w = '0;
      errors = 0;
      test_errors_start = 0;
      tests_run = 0;
      tests_bad = 0;
      rng = 32'h657c_3b79;
      end_gap = 4;
      advance(16);
      reset = 1'b0;
      advance(2);
      bus_access(1'b0, REG_COUNT, '0);
      close_test("reset values");

      // Single strobes followed by coinciding ones
      issue(ACT_STI, 1'b0, 1'b0);
      issue(ACT_CLI, 1'b0, 1'b0);
      issue(ACT_NOP, 1'b1, 1'b1);
      issue(ACT_NOP, 1'b1, 1'b0);
      issue(ACT_CLI, 1'b1, 1'b1);
      issue(ACT_STI, 1'b1, 1'b0);
      bus_access(1'b1, REG_CONTROL, 16'h0002);
      bus_access(1'b1, REG_CONTROL, 16'h0001);
      bus_access(1'b1, REG_CONTROL, 16'h0003);
      // Microcode strobes land on the edge that takes the host write
      flagwe = 1'b1;
      ibus15 = 1'b1;
      bus_access(1'b1, REG_CONTROL, 16'h0002);
      action = ACT_STI;
      bus_access(1'b1, REG_CONTROL, 16'h0002);
      action = ACT_CLI;
      bus_access(1'b1, REG_CONTROL, 16'h0001);
      close_test("flag priority");

      // Masked line followed by a pulse too short for the filter
      irq_n = 1'b0;
      advance(30);
      irq_n = 1'b1;
      advance(4);
      issue(ACT_STI, 1'b0, 1'b0);
      irq_n = 1'b0;
      advance(FILTER_LEN - 1);
      irq_n = 1'b1;
      advance(20);
      close_test("masking and filter");

      irq_n = 1'b0;
      wait_for_irqs(1'b1);
      issue(ACT_CLI, 1'b0, 1'b0);
      advance(2);
      irq_n = 1'b1;
      advance(5);
      close_test("request and cli");

      // Line released right after the request reaches the control unit
      issue(ACT_STI, 1'b0, 1'b0);
      irq_n = 1'b0;
      wait_for_irqs(1'b1);
      irq_n = 1'b1;
      wait_for_irqs(1'b0);
      advance(20);
      close_test("request withdrawn");

      // First status read sees the last edge before the filter accepts the line
      irq_n = 1'b0;
      advance(FILTER_LEN + 1);
      bus_access(1'b0, REG_STATUS, '0);
      wait_for_irqs(1'b1);
      bus_access(1'b0, REG_STATUS, '0);
      bus_access(1'b0, REG_COUNT, '0);
      bus_access(1'b1, REG_COUNT, 16'hffff);
      bus_access(1'b0, REG_COUNT, '0);
      bus_access(1'b0, REG_CONTROL, '0);
      // Unmapped slot
      bus_access(1'b1, 2'd3, 16'h0003);
      bus_access(1'b0, 2'd3, '0);
      irq_n = 1'b1;
      wait_for_irqs(1'b0);
      bus_access(1'b0, REG_STATUS, '0);
      close_test("register port");

      $display("tests run %0d, tests with errors %0d, failed checks %0d",
         tests_run, tests_bad, errors);
      if (errors == 0) begin
         $display("Simulation passed");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

/* int_unit.f */
design/int_pkg.sv
design/int_wb_pkg.sv
design/irq_sync.sv
design/int_fsm.sv
design/int_regs.sv
design/int_unit.sv
verification/tb_int_unit.sv
